// File: Bender.yml
package:
  name: vec_unit

sources:
  - files:
      - src/vec_cfg_pkg.sv
      - src/vec_insn_pkg.sv
      - src/vec_vrf.sv
      - src/vec_lane.sv
      - src/vec_sequencer.sv
      - src/vec_dispatcher.sv
      - src/vec_unit.sv
  - target: test
    files:
      - tests/vec_clk_gen.sv
      - tests/vec_unit_assert.sv
      - tests/vec_tb.sv

// File: src/vec_cfg_pkg.sv
// Sizing constants and element types of the vector datapath, imported by every RTL block
`default_nettype none

package vec_cfg_pkg;

  ////////////////////
  // Sizing
  ////////////////////

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VLenElems    = 8;
  // Element i lives in lane i mod NrLanes, slot i div NrLanes
  localparam int unsigned ElemsPerLane = VLenElems / NrLanes;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [ElemWidth-1:0]             elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]       vreg_idx_t;
  typedef logic [$clog2(VLenElems)-1:0]     elem_idx_t;
  typedef logic [$clog2(ElemsPerLane)-1:0]  slot_idx_t;
  typedef logic [$clog2(NrLanes)-1:0]       lane_idx_t;

  // Lane that owns an element
  function automatic lane_idx_t elem_lane(elem_idx_t idx);
    return lane_idx_t'(idx % NrLanes);
  endfunction

  // Slot of an element inside its lane
  function automatic slot_idx_t elem_slot(elem_idx_t idx);
    return slot_idx_t'(idx / NrLanes);
  endfunction

endpackage : vec_cfg_pkg

`default_nettype wire

// File: src/vec_dispatcher.sv
// Host-facing decoder: accepts one instruction, rejects illegal opcodes and returns the response
`default_nettype none

module vec_dispatcher import vec_cfg_pkg::*, vec_insn_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Host request and response
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  // Sequencer
  output pe_req_t   pe_req_o,
  output logic      pe_req_valid_o,
  input  logic      pe_req_ready_i,
  input  logic      pe_done_i,
  input  elem_t     pe_result_i
);

  typedef enum logic [1:0] {IDLE, ISSUE, RESPOND} state_e;

  state_e    state_q, state_d;
  logic      issued_q;
  vop_e      op;
  pe_req_t   pe_req_dec, pe_req_q;
  acc_resp_t resp_q;

  ////////////////////
  // Decode
  ////////////////////

  assign op = acc_req_i.insn.arith.op;

  // Format chosen by opcode
  always_comb begin
    pe_req_dec        = '0;
    pe_req_dec.op     = op;
    pe_req_dec.scalar = acc_req_i.scalar;
    case (op)
      VSPLAT: pe_req_dec.vd = acc_req_i.insn.move.vreg;
      VEXT: begin
        pe_req_dec.vs1  = acc_req_i.insn.move.vreg;
        pe_req_dec.eidx = acc_req_i.insn.move.eidx;
      end
      default: begin
        pe_req_dec.vd  = acc_req_i.insn.arith.vd;
        pe_req_dec.vs1 = acc_req_i.insn.arith.vs1;
        pe_req_dec.vs2 = acc_req_i.insn.arith.vs2;
      end
    endcase
  end

  ////////////////////
  // FSM
  ////////////////////

  assign acc_req_ready_o  = (state_q == IDLE);
  assign acc_resp_valid_o = (state_q == RESPOND);
  assign acc_resp_o       = resp_q;
  assign pe_req_o         = pe_req_q;
  assign pe_req_valid_o   = (state_q == ISSUE) && !issued_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (acc_req_valid_i) state_d = vop_legal(op) ? ISSUE : RESPOND;
      ISSUE:   if (pe_done_i) state_d = RESPOND;
      RESPOND: if (acc_resp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      issued_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (pe_req_valid_o && pe_req_ready_i) begin
        issued_q <= 1'b1;
      end else if (pe_done_i) begin
        issued_q <= 1'b0;
      end
    end
  end

  // Illegal opcodes get their error response at acceptance
  always_ff @(posedge clk_i) begin
    if (acc_req_valid_i && acc_req_ready_o) begin
      pe_req_q <= pe_req_dec;
      resp_q   <= '{result: '0, error: !vop_legal(op)};
    end else if ((state_q == ISSUE) && pe_done_i) begin
      resp_q <= '{result: pe_result_i, error: 1'b0};
    end
  end

endmodule : vec_dispatcher

`default_nettype wire

// File: src/vec_insn_pkg.sv
// Opcodes, instruction word formats and the request and response structs between the blocks
`default_nettype none

package vec_insn_pkg;

  import vec_cfg_pkg::*;

  ////////////////////
  // Opcodes
  ////////////////////

  // Codes 7 to 15 are illegal
  typedef enum logic [3:0] {
    VADD   = 4'd0,
    VSUB   = 4'd1,
    VAND   = 4'd2,
    VOR    = 4'd3,
    VXOR   = 4'd4,
    VSPLAT = 4'd5,
    VEXT   = 4'd6
  } vop_e;

  function automatic logic vop_legal(vop_e op);
    return op <= VEXT;
  endfunction

  ////////////////////
  // Instruction word
  ////////////////////

  // Vector-vector format
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    logic [2:0] spare;
  } arith_fmt_t;

  // Splat and extract format, opcode in the same place
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vreg;
    elem_idx_t eidx;
    logic [5:0] spare;
  } move_fmt_t;

  typedef union packed {
    arith_fmt_t arith;
    move_fmt_t  move;
  } vinsn_u;

  ////////////////////
  // Channels
  ////////////////////

  typedef struct packed {
    vinsn_u insn;
    elem_t  scalar;
  } acc_req_t;

  typedef struct packed {
    elem_t result;
    logic  error;
  } acc_resp_t;

  // Decoded instruction as seen by sequencer and lanes
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_idx_t eidx;
    elem_t     scalar;
  } pe_req_t;

endpackage : vec_insn_pkg

`default_nettype wire

// File: src/vec_lane.sv
// One vector lane: steps element operations over its slice of the register file
`default_nettype none

module vec_lane import vec_cfg_pkg::*, vec_insn_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Sequencer broadcast
  input  pe_req_t lane_req_i,
  input  logic    lane_req_valid_i,
  output logic    lane_done_o,
  output elem_t   lane_elem_o
);

  localparam slot_idx_t LastSlot = slot_idx_t'(ElemsPerLane - 1);

  pe_req_t   req_q;
  logic      active_q;
  slot_idx_t slot_q;
  logic      is_ext;
  logic      last;
  slot_idx_t rslot;
  elem_t     opa, opb;
  elem_t     result;

  assign is_ext = (req_q.op == VEXT);
  // Extract takes a single cycle, the rest one cycle per slot
  assign last   = is_ext || (slot_q == LastSlot);
  assign rslot  = is_ext ? elem_slot(req_q.eidx) : slot_q;

  assign lane_done_o = active_q && last;
  // Sequencer picks the owning lane
  assign lane_elem_o = opa;

  ////////////////////
  // Slot counter
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      slot_q   <= '0;
    end else if (lane_req_valid_i) begin
      active_q <= 1'b1;
      slot_q   <= '0;
    end else if (active_q) begin
      active_q <= !last;
      slot_q   <= last ? '0 : slot_q + slot_idx_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_req_valid_i) begin
      req_q <= lane_req_i;
    end
  end

  ////////////////////
  // ALU
  ////////////////////

  // Wraparound arithmetic
  always_comb begin
    case (req_q.op)
      VADD:    result = opa + opb;
      VSUB:    result = opa - opb;
      VAND:    result = opa & opb;
      VOR:     result = opa | opb;
      VXOR:    result = opa ^ opb;
      VSPLAT:  result = req_q.scalar;
      default: result = '0;
    endcase
  end

  // Reads are combinational so vd may alias vs1 or vs2
  vec_vrf i_vrf (
    .clk_i     (clk_i                  ),
    .arst_n_i  (arst_n_i               ),
    .raddr_a_i (req_q.vs1              ),
    .raddr_b_i (req_q.vs2              ),
    .rslot_i   (rslot                  ),
    .rdata_a_o (opa                    ),
    .rdata_b_o (opb                    ),
    .we_i      (active_q && !is_ext    ),
    .waddr_i   (req_q.vd               ),
    .wslot_i   (slot_q                 ),
    .wdata_i   (result                 )
  );

endmodule : vec_lane

`default_nettype wire

// File: src/vec_sequencer.sv
// Broadcasts one instruction to all lanes, waits for every lane and returns the extracted element
`default_nettype none

module vec_sequencer import vec_cfg_pkg::*, vec_insn_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Dispatcher
  input  pe_req_t               pe_req_i,
  input  logic                  pe_req_valid_i,
  output logic                  pe_req_ready_o,
  output logic                  pe_done_o,
  output elem_t                 pe_result_o,
  // Lanes
  output pe_req_t               lane_req_o,
  output logic                  lane_req_valid_o,
  input  logic    [NrLanes-1:0] lane_done_i,
  input  elem_t   [NrLanes-1:0] lane_elem_i
);

  pe_req_t              req_q;
  logic                 busy_q;
  logic                 bcast_q;
  logic                 done_q;
  logic   [NrLanes-1:0] pending_q;
  logic   [NrLanes-1:0] pending_d;
  elem_t                result_q;
  lane_idx_t            owner;
  logic                 accept;

  assign accept           = pe_req_valid_i && !busy_q;
  assign pe_req_ready_o   = !busy_q;
  assign lane_req_o       = req_q;
  assign lane_req_valid_o = bcast_q;
  assign pe_done_o        = done_q;
  assign pe_result_o      = result_q;

  // Lanes that still have to report
  assign pending_d = pending_q & ~lane_done_i;
  assign owner     = elem_lane(req_q.eidx);

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      bcast_q   <= 1'b0;
      done_q    <= 1'b0;
      pending_q <= '0;
    end else begin
      bcast_q <= accept;
      done_q  <= busy_q && (pending_d == '0);
      if (accept) begin
        busy_q    <= 1'b1;
        pending_q <= '1;
      end else if (busy_q) begin
        pending_q <= pending_d;
        if (pending_d == '0) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  // Only the owning lane holds the extracted element
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q    <= pe_req_i;
      result_q <= '0;
    end else if (busy_q && lane_done_i[owner] && (req_q.op == VEXT)) begin
      result_q <= lane_elem_i[owner];
    end
  end

endmodule : vec_sequencer

`default_nettype wire

// File: src/vec_unit.sv
// Top level of the vector coprocessor: dispatcher, sequencer and the lanes behind a host channel
`default_nettype none

module vec_unit import vec_cfg_pkg::*, vec_insn_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Host
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  ////////////////////
  // Dispatcher
  ////////////////////

  pe_req_t pe_req;
  logic    pe_req_valid;
  logic    pe_req_ready;
  logic    pe_done;
  elem_t   pe_result;

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .arst_n_i         (arst_n_i        ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .pe_req_o         (pe_req          ),
    .pe_req_valid_o   (pe_req_valid    ),
    .pe_req_ready_i   (pe_req_ready    ),
    .pe_done_i        (pe_done         ),
    .pe_result_i      (pe_result       )
  );

  ////////////////////
  // Sequencer
  ////////////////////

  pe_req_t               lane_req;
  logic                  lane_req_valid;
  logic    [NrLanes-1:0] lane_done;
  elem_t   [NrLanes-1:0] lane_elem;

  vec_sequencer i_sequencer (
    .clk_i            (clk_i         ),
    .arst_n_i         (arst_n_i      ),
    .pe_req_i         (pe_req        ),
    .pe_req_valid_i   (pe_req_valid  ),
    .pe_req_ready_o   (pe_req_ready  ),
    .pe_done_o        (pe_done       ),
    .pe_result_o      (pe_result     ),
    .lane_req_o       (lane_req      ),
    .lane_req_valid_o (lane_req_valid),
    .lane_done_i      (lane_done     ),
    .lane_elem_i      (lane_elem     )
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId (l)
    ) i_lane (
      .clk_i            (clk_i         ),
      .arst_n_i         (arst_n_i      ),
      .lane_req_i       (lane_req      ),
      .lane_req_valid_i (lane_req_valid),
      .lane_done_o      (lane_done[l]  ),
      .lane_elem_o      (lane_elem[l]  )
    );
  end : gen_lanes

endmodule : vec_unit

`default_nettype wire

// File: src/vec_vrf.sv
// Register file slice of one lane: two combinational read ports and one synchronous write port
`default_nettype none

module vec_vrf import vec_cfg_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Read ports share the slot
  input  vreg_idx_t raddr_a_i,
  input  vreg_idx_t raddr_b_i,
  input  slot_idx_t rslot_i,
  output elem_t     rdata_a_o,
  output elem_t     rdata_b_o,
  // Write port
  input  logic      we_i,
  input  vreg_idx_t waddr_i,
  input  slot_idx_t wslot_i,
  input  elem_t     wdata_i
);

  elem_t [NrVRegs-1:0][ElemsPerLane-1:0] regs_q;

  assign rdata_a_o = regs_q[raddr_a_i][rslot_i];
  assign rdata_b_o = regs_q[raddr_b_i][rslot_i];

  // Registers start out at zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '0;
    end else if (we_i) begin
      regs_q[waddr_i][wslot_i] <= wdata_i;
    end
  end

endmodule : vec_vrf

`default_nettype wire

// File: tests/vec_clk_gen.sv
// Testbench clock and active-low reset source, instantiated once by the testbench top
`default_nettype none

module vec_clk_gen #(
  parameter int unsigned Period      = 10,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, away from sampling
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule : vec_clk_gen

`default_nettype wire

// File: tests/vec_tb.sv
// Testbench of the vector unit: directed and random instructions checked against a reference model
`default_nettype none

module vec_tb import vec_cfg_pkg::*, vec_insn_pkg::*; ();

  localparam int unsigned ClkPeriod     = 10;
  localparam int unsigned ResetCycles   = 10;
  localparam int unsigned NrRandArith   = 100;
  localparam int unsigned ExtPerArith   = 2;
  localparam int unsigned NrAlias       = 4;
  localparam int unsigned NrBpArith     = 20;
  localparam int unsigned CyclesPerInsn = 200;
  // Splat and dump, random, aliasing, illegal codes, back-pressure and final dump
  localparam int unsigned NrInsns = (NrVRegs + NrVRegs * VLenElems)
    + NrRandArith * (1 + ExtPerArith) + NrAlias * (1 + VLenElems)
    + (9 + NrVRegs * VLenElems) + NrBpArith * (1 + ExtPerArith) + NrVRegs * VLenElems;

  logic        clk, arst_n;
  acc_req_t    acc_req;
  logic        acc_req_valid, acc_req_ready;
  acc_resp_t   acc_resp;
  logic        acc_resp_valid, acc_resp_ready;
  logic        bp_en;
  int unsigned n_issued, n_checked;
  elem_t       ref_vrf [NrVRegs][VLenElems];
  acc_resp_t   exp_q [$];

  vec_clk_gen #(.Period(ClkPeriod), .ResetCycles(ResetCycles)) u_clk (
    .clk_o    (clk   ),
    .arst_n_o (arst_n)
  );

  vec_unit u_dut (
    .clk_i            (clk           ),
    .arst_n_i         (arst_n        ),
    .acc_req_i        (acc_req       ),
    .acc_req_valid_i  (acc_req_valid ),
    .acc_req_ready_o  (acc_req_ready ),
    .acc_resp_o       (acc_resp      ),
    .acc_resp_valid_o (acc_resp_valid),
    .acc_resp_ready_i (acc_resp_ready)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_result(input elem_t got, input elem_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch acc_resp_o.result got 0x%08h expected 0x%08h", got, exp));
    end
  endtask

  task automatic check_error(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch acc_resp_o.error got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic elem_t ref_alu(input logic [3:0] code, input elem_t a, input elem_t b);
    case (code)
      4'd0:    return a + b;
      4'd1:    return a - b;
      4'd2:    return a & b;
      4'd3:    return a | b;
      default: return a ^ b;
    endcase
  endfunction

  // Element-wise, so vd aliasing vs1 or vs2 still sees old values
  function automatic acc_resp_t ref_model(input acc_req_t req);
    acc_resp_t  resp;
    logic [3:0] code;
    resp = '0;
    code = req.insn.arith.op;
    if (code > 4'd6) begin
      resp.error = 1'b1;
    end else if (code == 4'd5) begin
      for (int e = 0; e < VLenElems; e++) begin
        ref_vrf[req.insn.move.vreg][e] = req.scalar;
      end
    end else if (code == 4'd6) begin
      resp.result = ref_vrf[req.insn.move.vreg][req.insn.move.eidx];
    end else begin
      for (int e = 0; e < VLenElems; e++) begin
        ref_vrf[req.insn.arith.vd][e] = ref_alu(code, ref_vrf[req.insn.arith.vs1][e],
                                                ref_vrf[req.insn.arith.vs2][e]);
      end
    end
    return resp;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic acc_req_t arith_req(input int unsigned code, input int unsigned vd,
                                         input int unsigned vs1, input int unsigned vs2);
    acc_req_t req;
    req                = '0;
    req.insn.arith.op  = vop_e'(code[3:0]);
    req.insn.arith.vd  = vreg_idx_t'(vd);
    req.insn.arith.vs1 = vreg_idx_t'(vs1);
    req.insn.arith.vs2 = vreg_idx_t'(vs2);
    return req;
  endfunction

  function automatic acc_req_t move_req(input int unsigned code, input int unsigned vreg,
                                        input int unsigned eidx, input elem_t scalar);
    acc_req_t req;
    req                = '0;
    req.insn.move.op   = vop_e'(code[3:0]);
    req.insn.move.vreg = vreg_idx_t'(vreg);
    req.insn.move.eidx = elem_idx_t'(eidx);
    req.scalar         = scalar;
    return req;
  endfunction

  // Holds the request until the DUT takes it
  task automatic issue(input acc_req_t req);
    exp_q.push_back(ref_model(req));
    n_issued++;
    acc_req       = req;
    acc_req_valid = 1'b1;
    do @(posedge clk); while (!acc_req_ready);
    #1;
    acc_req_valid = 1'b0;
  endtask

  task automatic dump_reg(input int unsigned vreg);
    for (int e = 0; e < VLenElems; e++) begin
      issue(move_req(VEXT, vreg, e, '0));
    end
  endtask

  task automatic dump_all();
    for (int r = 0; r < NrVRegs; r++) begin
      dump_reg(r);
    end
  endtask

  task automatic random_arith_step();
    int unsigned vd;
    vd = $urandom_range(0, NrVRegs - 1);
    issue(arith_req($urandom_range(0, 4), vd, $urandom_range(0, NrVRegs - 1),
                    $urandom_range(0, NrVRegs - 1)));
    for (int k = 0; k < ExtPerArith; k++) begin
      issue(move_req(VEXT, vd, $urandom_range(0, VLenElems - 1), '0));
    end
  endtask

  // Host stalls about a third of the cycles when enabled
  always @(posedge clk) begin
    #1;
    acc_resp_ready = bp_en ? ($urandom_range(0, 2) != 0) : 1'b1;
  end

  ////////////////////
  // Compare
  ////////////////////

  always @(posedge clk) begin : compare
    acc_resp_t exp;
    if (arst_n && acc_resp_valid && acc_resp_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("response arrived with no instruction outstanding");
      end else begin
        exp = exp_q.pop_front();
        check_error(acc_resp.error, exp.error);
        check_result(acc_resp.result, exp.result);
        n_checked++;
      end
    end
  end

  always @(u_dut.u_assert.nr_errors) begin
    if (u_dut.u_assert.nr_errors != 0) begin
      abort_run("handshake assertion on the host channel failed");
    end
  end

  initial begin : watchdog
    #(ClkPeriod * (ResetCycles + 2 + CyclesPerInsn * NrInsns));
    abort_run($sformatf("timeout with %0d of %0d responses checked", n_checked, n_issued));
  end

  initial begin : main
    void'($urandom(32'ha04237fa));
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b1;
    bp_en          = 1'b0;
    n_issued       = 0;
    n_checked      = 0;
    // Register file comes out of reset cleared
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < VLenElems; e++) begin
        ref_vrf[r][e] = '0;
      end
    end
    @(posedge arst_n);
    @(posedge clk);
    #1;
    // Distinct splats, then every element back
    for (int r = 0; r < NrVRegs; r++) begin
      issue(move_req(VSPLAT, r, 0, 32'h1111_1111 * (r + 1)));
    end
    dump_all();
    for (int i = 0; i < NrRandArith; i++) begin
      random_arith_step();
    end
    // Destination aliases a source
    for (int i = 0; i < NrAlias; i++) begin
      if (i % 2 == 0) begin
        issue(arith_req(i % 5, i, i, (i + 3) % NrVRegs));
      end else begin
        issue(arith_req(i % 5, i, (i + 5) % NrVRegs, i));
      end
      dump_reg(i);
    end
    for (int code = 7; code < 16; code++) begin
      issue(arith_req(code, $urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7)));
    end
    dump_all();
    bp_en = 1'b1;
    for (int i = 0; i < NrBpArith; i++) begin
      random_arith_step();
    end
    dump_all();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // Unit back in idle once the last response is taken
    if (acc_req_ready && !acc_resp_valid) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("unit not idle after the last response was taken");
    end
  end

endmodule : vec_tb

`default_nettype wire

// File: tests/vec_unit_assert.sv
// Handshake checks on the host channel of the vector unit, bound into every vec_unit instance
`default_nettype none

module vec_unit_assert import vec_insn_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      req_valid_i,
  input logic      req_ready_i,
  input acc_resp_t resp_i,
  input logic      resp_valid_i,
  input logic      resp_ready_i
);

  // Count of failed assertions
  int unsigned nr_errors = 0;
  // Request taken and its response not yet delivered
  logic        pending_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= (pending_q && !(resp_valid_i && resp_ready_i))
                   || (req_valid_i && req_ready_i);
    end
  end

  // Response held while the host stalls
  resp_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
    else begin
      $error("response changed or dropped under back-pressure");
      nr_errors++;
    end

  no_accept_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pending_q |-> !(req_valid_i && req_ready_i))
    else begin
      $error("request accepted while a response was pending");
      nr_errors++;
    end

  reset_quiet_a: assert property (@(posedge clk_i) !arst_n_i |-> !resp_valid_i)
    else begin
      $error("response valid during reset");
      nr_errors++;
    end

endmodule : vec_unit_assert

bind vec_unit vec_unit_assert u_assert (
  .clk_i        (clk_i           ),
  .arst_n_i     (arst_n_i        ),
  .req_valid_i  (acc_req_valid_i ),
  .req_ready_i  (acc_req_ready_o ),
  .resp_i       (acc_resp_o      ),
  .resp_valid_i (acc_resp_valid_o),
  .resp_ready_i (acc_resp_ready_i)
);

`default_nettype wire

// File: vec_unit.f
src/vec_cfg_pkg.sv
src/vec_insn_pkg.sv
src/vec_vrf.sv
src/vec_lane.sv
src/vec_sequencer.sv
src/vec_dispatcher.sv
src/vec_unit.sv
tests/vec_clk_gen.sv
tests/vec_unit_assert.sv
tests/vec_tb.sv
